// ==== hdl/accControl.sv ====
//----------------------------------------------------------------------
// HI/LO accumulator.
// Loads, adds or subtracts the multiplier product; flags describe the
// value that the next update will store.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module accControl (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 accEn,     // Update on this edge.
    input  logic [1:0]           accMode,   // Load, add or subtract.
    input  logic [2*`DATA_W-1:0] product,
    output exPkg::accWordT       accOut,
    output logic                 accC,      // Carry, or borrow on subtract.
    output logic                 accZ,
    output logic                 accO,      // Signed overflow.
    output logic                 accN
);

    exPkg::accWordT       accReg;
    exPkg::accWordT       accNext;
    logic [2*`DATA_W:0]   addSum;           // 65-bit sum with carry.
    logic [2*`DATA_W-1:0] subDiff;

    assign addSum  = {1'b0, accReg.full} + {1'b0, product};
    assign subDiff = accReg.full - product;

    always_comb begin
        accNext.full = product;
        accC         = 1'b0;
        accO         = 1'b0;
        case (accMode)
            `ACC_ADD: begin
                accNext.full = addSum[2*`DATA_W-1:0];
                accC         = addSum[2*`DATA_W];
                accO = (accReg.full[2*`DATA_W-1] == product[2*`DATA_W-1]) &&
                       (accNext.full[2*`DATA_W-1] != accReg.full[2*`DATA_W-1]);
            end
            `ACC_SUB: begin
                accNext.full = subDiff;
                accC         = accReg.full < product;
                accO = (accReg.full[2*`DATA_W-1] != product[2*`DATA_W-1]) &&
                       (accNext.full[2*`DATA_W-1] != accReg.full[2*`DATA_W-1]);
            end
            default: accNext.full = product;   // Plain MULT/MULTU.
        endcase
    end

    assign accZ = (accNext.full == '0);
    assign accN = accNext.full[2*`DATA_W-1];

    always_ff @(posedge Clock) begin
        if (rst) begin
            accReg.full <= '0;
        end else if (accEn) begin
            accReg <= accNext;
        end
    end

    assign accOut = accReg;

    // Enable is decoded in exControl; an X here would corrupt HI/LO.
    accEnKnown: assert property (@(posedge Clock) disable iff (rst) !$isunknown(accEn))
        else $error("accControl: accEn unknown");

endmodule

// ==== hdl/alu.sv ====
//----------------------------------------------------------------------
// ALU.
// Add, subtract, logic, set-less-than and shifts with C/Z/O/N flags.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module alu (
    input  logic [`DATA_W-1:0] a,        // Operand A (rs).
    input  logic [`DATA_W-1:0] b,        // Operand B (rt or immediate).
    input  logic [4:0]         shamt,    // Shift amount.
    input  exPkg::aluFnT       aluFn,
    output logic [`DATA_W-1:0] aluOut,
    output logic               c,        // Carry, or borrow on subtract.
    output logic               z,        // Result is zero.
    output logic               o,        // Signed overflow.
    output logic               n         // Result is negative.
);

    logic [`DATA_W:0]   sum;             // Add with carry out.
    logic [`DATA_W-1:0] diff;
    logic               borrow;
    logic               addOvf;
    logic               subOvf;

    assign sum    = {1'b0, a} + {1'b0, b};
    assign diff   = a - b;
    assign borrow = a < b;               // Unsigned borrow.
    assign addOvf = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
    assign subOvf = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);

    always_comb begin
        aluOut = '0;
        c      = 1'b0;
        o      = 1'b0;
        case (aluFn)
            exPkg::aluAdd, exPkg::aluAddu: begin
                aluOut = sum[`DATA_W-1:0];
                c      = sum[`DATA_W];
                o      = addOvf;
            end
            exPkg::aluSub, exPkg::aluSubu: begin
                aluOut = diff;
                c      = borrow;
                o      = subOvf;
            end
            exPkg::aluAnd:  aluOut = a & b;
            exPkg::aluOr:   aluOut = a | b;
            exPkg::aluXor:  aluOut = a ^ b;
            exPkg::aluNor:  aluOut = ~(a | b);
            exPkg::aluSlt:  aluOut = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            exPkg::aluSltu: aluOut = {{(`DATA_W-1){1'b0}}, borrow};
            exPkg::aluSll:  aluOut = b << shamt;           // MIPS shifts rt.
            exPkg::aluSrl:  aluOut = b >> shamt;
            exPkg::aluSra:  aluOut = $signed(b) >>> shamt;
            default:        aluOut = '0;
        endcase
    end

    assign z = (aluOut == '0);
    assign n = aluOut[`DATA_W-1];

    //------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------
    // The decode in exControl must only hand over real ALU codes.
    always_comb begin
        assert final ($isunknown(aluFn) || aluFn inside {
            exPkg::aluSll, exPkg::aluSrl, exPkg::aluSra,
            exPkg::aluAdd, exPkg::aluAddu, exPkg::aluSub, exPkg::aluSubu,
            exPkg::aluAnd, exPkg::aluOr, exPkg::aluXor, exPkg::aluNor,
            exPkg::aluSlt, exPkg::aluSltu})
        else $error("alu: unknown function code %h", aluFn);
    end

endmodule

// ==== hdl/exControl.sv ====
//----------------------------------------------------------------------
// Execute control.
// Decodes funct, picks result and flags, forms next PC and gates the
// register write.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module exControl (
    input  logic               aluOp,
    input  logic               mulOp,
    input  logic               jump,
    input  logic               branch,
    input  logic               regWriteIn,
    input  logic [5:0]         func,
    input  logic [`DATA_W-1:0] pcIn,
    input  logic [`DATA_W-1:0] immediate,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] aluOut,
    input  logic [`DATA_W-1:0] productLo,
    input  exPkg::accWordT     accOut,
    input  logic               aluC,
    input  logic               aluZ,
    input  logic               aluO,
    input  logic               aluN,
    input  logic               accC,
    input  logic               accZ,
    input  logic               accO,
    input  logic               accN,
    output exPkg::aluFnT       aluFn,
    output logic               mulSigned,
    output logic               accEn,
    output logic [1:0]         accMode,
    output logic [`DATA_W-1:0] out,
    output logic [`DATA_W-1:0] pcOut,
    output logic               c,
    output logic               z,
    output logic               o,
    output logic               n,
    output logic               regWriteOut
);

    logic isMfhi;
    logic isMflo;

    assign isMfhi = aluOp && !mulOp && (func == `FN_MFHI);
    assign isMflo = aluOp && !mulOp && (func == `FN_MFLO);

    // ALU runs func for R-type ops, ADD for address and immediate maths.
    assign aluFn = (aluOp && !mulOp && !isMfhi && !isMflo) ? exPkg::aluFnT'(func)
                                                           : exPkg::aluAdd;

    // Multiply decode.
    always_comb begin
        accEn     = 1'b0;
        accMode   = `ACC_LOAD;
        mulSigned = ~func[0];            // Even codes are the signed forms.
        if (mulOp) begin
            case (func)
                `FN_MULT, `FN_MULTU: accEn = 1'b1;
                `FN_MADD, `FN_MADDU: begin
                    accEn   = 1'b1;
                    accMode = `ACC_ADD;
                end
                `FN_MSUB, `FN_MSUBU: begin
                    accEn   = 1'b1;
                    accMode = `ACC_SUB;
                end
                default: accEn = 1'b0;
            endcase
        end
    end

    assign out = mulOp  ? productLo :
                 isMfhi ? accOut.half.hi :
                 isMflo ? accOut.half.lo : aluOut;

    assign {c, z, o, n} = mulOp ? {accC, accZ, accO, accN} : {aluC, aluZ, aluO, aluN};

    // Branch tests the raw ALU zero flag.
    assign pcOut = (branch && aluZ) ? pcIn + (immediate << 2) :
                   jump             ? a : pcIn;

    assign regWriteOut = regWriteIn && !mulOp;   // Multiplies write HI/LO only.

    always_comb begin
        assert final (!(branch === 1'b1 && jump === 1'b1))
        else $error("exControl: branch and jump both high");
    end

endmodule

// ==== hdl/exMult.sv ====
//----------------------------------------------------------------------
// Multiplier.
// 32x32 to 64-bit product, signed or unsigned operands.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module exMult (
    input  logic [`DATA_W-1:0]   a,
    input  logic [`DATA_W-1:0]   b,
    input  logic                 mulSigned,  // High for MULT/MADD/MSUB.
    output logic [2*`DATA_W-1:0] product
);

    // One extra bit per operand so a single signed multiply covers both cases.
    logic signed [`DATA_W:0]     aExt;
    logic signed [`DATA_W:0]     bExt;
    logic signed [2*`DATA_W+1:0] prodFull;

    assign aExt = {mulSigned & a[`DATA_W-1], a};   // Sign or zero extend.
    assign bExt = {mulSigned & b[`DATA_W-1], b};

    assign prodFull = aExt * bExt;
    assign product  = prodFull[2*`DATA_W-1:0];     // Upper bits are extension only.

endmodule

// ==== hdl/exPkg.sv ====
//----------------------------------------------------------------------
// Execute stage types.
// HI/LO accumulator word and the ALU function encoding.
//----------------------------------------------------------------------
`include "ex_params.svh"

package exPkg;

    // Accumulator seen whole for add/sub, or as HI and LO for moves.
    typedef union packed {
        logic [2*`DATA_W-1:0] full;
        struct packed {
            logic [`DATA_W-1:0] hi;
            logic [`DATA_W-1:0] lo;
        } half;
    } accWordT;

    // Functions the ALU itself implements.
    typedef enum logic [5:0] {
        aluSll  = `FN_SLL,
        aluSrl  = `FN_SRL,
        aluSra  = `FN_SRA,
        aluAdd  = `FN_ADD,
        aluAddu = `FN_ADDU,
        aluSub  = `FN_SUB,
        aluSubu = `FN_SUBU,
        aluAnd  = `FN_AND,
        aluOr   = `FN_OR,
        aluXor  = `FN_XOR,
        aluNor  = `FN_NOR,
        aluSlt  = `FN_SLT,
        aluSltu = `FN_SLTU
    } aluFnT;

endpackage

// ==== hdl/exStage.sv ====
//----------------------------------------------------------------------
// Execute stage top.
// Operand select, ALU, multiplier, HI/LO accumulator and control,
// with memory controls passed through to the next stage.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module exStage (
    input  logic               Clock,
    input  logic               rst,
    input  logic               aluOp,
    input  logic               mulOp,
    input  logic               jump,
    input  logic               branch,
    input  logic               regWriteIn,
    input  logic               memReadIn,
    input  logic               memtoRegIn,
    input  logic               memWriteIn,
    input  logic               aluSrc,     // Use immediate as operand B.
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic [`DATA_W-1:0] immediate,
    input  logic [`DATA_W-1:0] pcIn,
    input  logic [4:0]         shamt,
    input  logic [4:0]         rAddrIn,
    input  logic [5:0]         func,
    output logic [`DATA_W-1:0] out,
    output logic [`DATA_W-1:0] rtDataOut,
    output logic [`DATA_W-1:0] pcOut,
    output logic [4:0]         rAddrOut,
    output logic               c,
    output logic               z,
    output logic               o,
    output logic               n,
    output logic               regWriteOut,
    output logic               memReadOut,
    output logic               memtoRegOut,
    output logic               memWriteOut
);

    logic [`DATA_W-1:0]   opB;
    logic [`DATA_W-1:0]   aluOut;
    logic [2*`DATA_W-1:0] product;
    exPkg::accWordT       accOut;
    exPkg::aluFnT         aluFn;
    logic                 aluC, aluZ, aluO, aluN;
    logic                 accC, accZ, accO, accN;
    logic                 mulSigned;
    logic                 accEn;
    logic [1:0]           accMode;

    assign opB = aluSrc ? immediate : b;

    alu alu0 (
        .a(a), .b(opB), .shamt(shamt), .aluFn(aluFn), .aluOut(aluOut),
        .c(aluC), .z(aluZ), .o(aluO), .n(aluN)
    );

    exMult exMult0 (.a(a), .b(opB), .mulSigned(mulSigned), .product(product));

    accControl accControl0 (
        .Clock(Clock), .rst(rst), .accEn(accEn), .accMode(accMode), .product(product),
        .accOut(accOut), .accC(accC), .accZ(accZ), .accO(accO), .accN(accN)
    );

    exControl exControl0 (
        .aluOp(aluOp), .mulOp(mulOp), .jump(jump), .branch(branch),
        .regWriteIn(regWriteIn), .func(func), .pcIn(pcIn), .immediate(immediate),
        .a(a), .aluOut(aluOut), .productLo(product[`DATA_W-1:0]), .accOut(accOut),
        .aluC(aluC), .aluZ(aluZ), .aluO(aluO), .aluN(aluN),
        .accC(accC), .accZ(accZ), .accO(accO), .accN(accN),
        .aluFn(aluFn), .mulSigned(mulSigned), .accEn(accEn), .accMode(accMode),
        .out(out), .pcOut(pcOut), .c(c), .z(z), .o(o), .n(n),
        .regWriteOut(regWriteOut)
    );

    // Straight through to the memory stage.
    assign memReadOut  = memReadIn;
    assign memtoRegOut = memtoRegIn;
    assign memWriteOut = memWriteIn;
    assign rAddrOut    = rAddrIn;
    assign rtDataOut   = b;            // Store data is rt, not the muxed operand.

endmodule

// ==== hdl/ex_params.svh ====
//----------------------------------------------------------------------
// Execute stage parameters.
// Datapath width, MIPS funct codes and accumulator update modes.
//----------------------------------------------------------------------
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

`define DATA_W    32          // Datapath width.

// ALU funct codes.
`define FN_SLL    6'h00
`define FN_SRL    6'h02
`define FN_SRA    6'h03
`define FN_MFHI   6'h10
`define FN_MFLO   6'h12
`define FN_ADD    6'h20
`define FN_ADDU   6'h21
`define FN_SUB    6'h22
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_NOR    6'h27
`define FN_SLT    6'h2A
`define FN_SLTU   6'h2B

// Multiply funct codes, only meaningful with mulOp high.
`define FN_MULT   6'h18
`define FN_MULTU  6'h19
`define FN_MADD   6'h1C
`define FN_MADDU  6'h1D
`define FN_MSUB   6'h1E
`define FN_MSUBU  6'h1F

// Accumulator update modes.
`define ACC_LOAD  2'd0
`define ACC_ADD   2'd1
`define ACC_SUB   2'd2

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbExStage \
    -f verilog.f -Mdir obj_dir -o simTbExStage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTbExStage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== test/tbExStage.sv ====
//----------------------------------------------------------------------
// Execute stage testbench.
// Directed tests for ALU, operand select, multiply, HI/LO accumulate,
// next PC and reset, checked against a local model.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "ex_params.svh"

module tbExStage;

    localparam int timeoutCycles = 400;    // Tests run about 100 cycles.
    localparam logic [5:0] aluFns [13] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
        `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA};

    logic Clock, rst, aluOp, mulOp, jump, branch, regWriteIn, aluSrc;
    logic memReadIn, memtoRegIn, memWriteIn;
    logic [31:0] a, b, immediate, pcIn, out, rtDataOut, pcOut;
    logic [4:0]  shamt, rAddrIn, rAddrOut;
    logic [5:0]  func;
    logic c, z, o, n, regWriteOut, memReadOut, memtoRegOut, memWriteOut;

    logic [63:0] hiLo;                     // Shadow HI/LO.
    logic [8:0]  ctl;                      // Random pass-through controls.
    logic [31:0] pcNow;
    integer      seed = 32'h2a12_79c5;
    int          cycles = 0;
    int          failures = 0;

    exStage exStage_inst (.*);

    initial Clock = 1'b0;
    always #10 Clock = ~Clock;

    always @(posedge Clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [35:0] aluExpect(input logic [5:0] fn, input logic [31:0] x,
                                              input logic [31:0] y, input logic [4:0] sh);
        logic [31:0] r;
        logic [32:0] carry;
        logic [32:0] wide;                 // Sign extended, shows overflow.
        logic        cy;
        logic        ov;
        r  = '0;
        cy = 1'b0;
        ov = 1'b0;
        case (fn)
            `FN_ADD, `FN_ADDU: begin
                carry = {1'b0, x} + {1'b0, y};
                wide  = {x[31], x} + {y[31], y};
                r     = carry[31:0];
                cy    = carry[32];
                ov    = wide[32] != wide[31];
            end
            `FN_SUB, `FN_SUBU: begin
                wide = {x[31], x} - {y[31], y};
                r    = x - y;
                cy   = x < y;              // Borrow.
                ov   = wide[32] != wide[31];
            end
            `FN_AND:  r = x & y;
            `FN_OR:   r = x | y;
            `FN_XOR:  r = x ^ y;
            `FN_NOR:  r = ~(x | y);
            `FN_SLT:  r = {31'b0, $signed(x) < $signed(y)};
            `FN_SLTU: r = {31'b0, x < y};
            `FN_SLL:  r = y << sh;
            `FN_SRL:  r = y >> sh;
            `FN_SRA:  r = $unsigned($signed(y) >>> sh);
            default:  r = '0;
        endcase
        return {r, cy, r == 32'd0, ov, r[31]};
    endfunction

    function automatic logic [63:0] mulExpect(input logic [5:0] fn, input logic [31:0] x,
                                              input logic [31:0] y);
        if (fn == `FN_MULT || fn == `FN_MADD || fn == `FN_MSUB)
            return $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
        return {32'b0, x} * {32'b0, y};
    endfunction

    // Next HI/LO and its flags, packed as {value, c, z, o, n}.
    function automatic logic [67:0] accExpect(input logic [5:0] fn, input logic [63:0] acc,
                                              input logic [63:0] p);
        logic [64:0] carry;
        logic [64:0] wide;
        logic [63:0] nxt;
        logic        cy;
        logic        ov;
        nxt = p;
        cy  = 1'b0;
        ov  = 1'b0;
        if (fn == `FN_MADD || fn == `FN_MADDU) begin
            carry = {1'b0, acc} + {1'b0, p};
            wide  = {acc[63], acc} + {p[63], p};
            nxt   = carry[63:0];
            cy    = carry[64];
            ov    = wide[64] != wide[63];
        end else if (fn == `FN_MSUB || fn == `FN_MSUBU) begin
            wide = {acc[63], acc} - {p[63], p};
            nxt  = acc - p;
            cy   = acc < p;
            ov   = wide[64] != wide[63];
        end
        return {nxt, cy, nxt == 64'd0, ov, nxt[63]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            failures++;
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Drive one operation on the rising edge, return before the next edge.
    task automatic issue(input logic aluOpV, input logic mulOpV, input logic [5:0] fnV,
                         input logic [31:0] aV, input logic [31:0] bV,
                         input logic [31:0] immV, input logic srcV, input logic [4:0] shV,
                         input logic brV, input logic jmpV);
        @(posedge Clock);
        ctl   = 9'($random(seed));
        pcNow = $random(seed) & 32'hFFFF_FFFC;
        aluOp <= aluOpV;
        mulOp <= mulOpV;
        func <= fnV;
        a <= aV;
        b <= bV;
        immediate <= immV;
        aluSrc <= srcV;
        shamt <= shV;
        branch <= brV;
        jump <= jmpV;
        pcIn <= pcNow;
        {rAddrIn, memWriteIn, memtoRegIn, memReadIn} <= ctl[7:0];
        regWriteIn <= ctl[8] | mulOpV;    // Multiplies request a write that must be gated.
        @(negedge Clock);
    endtask

    task automatic checkPassThrough(input logic [31:0] bV);
        checkValue("rtDataOut", rtDataOut, bV);
        checkValue("rAddrOut", {27'b0, rAddrOut}, {27'b0, ctl[7:3]});
        checkValue("memWriteOut/memtoRegOut/memReadOut",
                   {29'b0, memWriteOut, memtoRegOut, memReadOut}, {29'b0, ctl[2:0]});
        checkValue("regWriteOut", {31'b0, regWriteOut}, {31'b0, ctl[8]});
        checkValue("pcOut", pcOut, pcNow);
    endtask

    task automatic aluCase(input logic [5:0] fn, input logic [31:0] x, input logic [31:0] y);
        logic [4:0]  sh;
        logic [35:0] exp;
        sh  = 5'($random(seed));
        exp = aluExpect(fn, x, y, sh);
        issue(1'b1, 1'b0, fn, x, y, 32'h0, 1'b0, sh, 1'b0, 1'b0);
        checkValue("out", out, exp[35:4]);
        checkValue("flags czon", {28'b0, c, z, o, n}, {28'b0, exp[3:0]});
        checkPassThrough(y);
    endtask

    task automatic mulCase(input logic [5:0] fn, input logic [31:0] x, input logic [31:0] y);
        logic [63:0] prod;
        logic [67:0] acc;
        prod = mulExpect(fn, x, y);
        acc  = accExpect(fn, hiLo, prod);
        issue(1'b1, 1'b1, fn, x, y, 32'h0, 1'b0, 5'd0, 1'b0, 1'b0);
        checkValue("out", out, prod[31:0]);
        checkValue("flags czon", {28'b0, c, z, o, n}, {28'b0, acc[3:0]});
        checkValue("regWriteOut", {31'b0, regWriteOut}, 32'd0);
        hiLo = acc[67:4];
    endtask

    task automatic readHiLo();
        issue(1'b1, 1'b0, `FN_MFHI, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0, 1'b0);
        checkValue("out (MFHI)", out, hiLo[63:32]);
        issue(1'b1, 1'b0, `FN_MFLO, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0, 1'b0);
        checkValue("out (MFLO)", out, hiLo[31:0]);
    endtask

    task automatic testAlu();
        foreach (aluFns[i]) begin
            aluCase(aluFns[i], 32'h7FFF_FFFF, 32'h0000_0001);  // Add overflow.
            aluCase(aluFns[i], 32'h0000_0000, 32'h0000_0001);  // Borrow.
            aluCase(aluFns[i], 32'h8000_0000, 32'h0000_0001);  // SLT vs SLTU.
            aluCase(aluFns[i], $random(seed), $random(seed));
            aluCase(aluFns[i], $random(seed), $random(seed));
        end
    endtask

    task automatic testOperandSelect();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] imm;
        repeat (4) begin
            x   = $random(seed);
            y   = $random(seed);
            imm = $random(seed);
            // Func is ignored with aluOp low.
            issue(1'b0, 1'b0, `FN_SUB, x, y, imm, 1'b1, 5'd0, 1'b0, 1'b0);
            checkValue("out", out, x + imm);
            checkPassThrough(y);
        end
    endtask

    task automatic testMultiply();
        mulCase(`FN_MULT, $random(seed), $random(seed));
        readHiLo();
        mulCase(`FN_MULTU, $random(seed), $random(seed));
        readHiLo();
    endtask

    task automatic testAccumulate();
        mulCase(`FN_MULT, 32'd3, 32'd5);
        mulCase(`FN_MADD, 32'hFFFF_FFFF, 32'd2);          // -2 onto 15, carries out.
        checkValue("c after MADD", {31'b0, c}, 32'd1);
        mulCase(`FN_MSUBU, 32'hFFFF_FFFF, 32'hFFFF_FFFF); // Borrows.
        mulCase(`FN_MADD, $random(seed), $random(seed));
        readHiLo();
    endtask

    task automatic testNextPc();
        logic [31:0] x;
        logic [31:0] imm;
        x   = $random(seed);
        imm = $random(seed) & 32'h0000_FFFF;
        issue(1'b1, 1'b0, `FN_SUB, x, x, imm, 1'b0, 5'd0, 1'b1, 1'b0);
        checkValue("pcOut (taken branch)", pcOut, pcNow + imm * 4);
        issue(1'b1, 1'b0, `FN_SUB, x, x ^ 32'h1, imm, 1'b0, 5'd0, 1'b1, 1'b0);
        checkValue("pcOut (branch not taken)", pcOut, pcNow);
        issue(1'b0, 1'b0, `FN_ADD, x, 32'h0, imm, 1'b0, 5'd0, 1'b0, 1'b1);
        checkValue("pcOut (jump)", pcOut, x);
    endtask

    task automatic testReset();
        @(posedge Clock);
        rst <= 1'b1;
        repeat (3) @(posedge Clock);
        rst <= 1'b0;
        hiLo = 64'd0;
        readHiLo();
    endtask

    initial begin
        {aluOp, mulOp, jump, branch, regWriteIn, aluSrc} = '0;
        {memReadIn, memtoRegIn, memWriteIn} = '0;
        {a, b, immediate, pcIn} = '0;
        {shamt, rAddrIn} = '0;
        func = `FN_ADD;
        hiLo = 64'd0;
        rst  = 1'b1;
        repeat (3) @(posedge Clock);
        rst <= 1'b0;

        testAlu();
        testOperandSelect();
        testMultiply();
        testAccumulate();
        testNextPc();
        testReset();

        if (failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/exPkg.sv
hdl/alu.sv
hdl/exMult.sv
hdl/accControl.sv
hdl/exControl.sv
hdl/exStage.sv
test/tbExStage.sv
